// File: source/bp_pkg.sv
// Branch predictor shared types
`default_nettype none

package bp_pkg;

    // address and target width
    localparam int xlen = 32;

    // instructions per fetch packet of 4 bytes each
    localparam int slots = 2;

    // bit 0 clear means predict taken
    typedef enum logic [1:0] {
        strong_taken = 2'b00,
        strong_not   = 2'b01,
        weak_taken   = 2'b10,
        weak_not     = 2'b11
    } ctr_t;

    localparam ctr_t ctr_reset = weak_taken;

endpackage

`default_nettype wire

// File: source/bp_target_ram.sv
// Branch target memory
`timescale 1ns/1ps
`default_nettype none

module bp_target_ram #(
    parameter int index_w = 8
) (
    input  logic                    clk,
    input  logic [index_w-1:0]      rd_addr,
    output logic [bp_pkg::xlen-1:0] rd_data,
    input  logic                    wr_en,
    input  logic [index_w-1:0]      wr_addr,
    input  logic [bp_pkg::xlen-1:0] wr_data
);
    import bp_pkg::*;

    logic [xlen-1:0] mem [1<<index_w];

    // same-cycle read returns the old word
    assign rd_data = mem[rd_addr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// File: source/bp_route.sv
// Fetch and resolve address router
`timescale 1ns/1ps
`default_nettype none

module bp_route #(
    parameter int index_w = 8
) (
    input  logic [bp_pkg::xlen-1:0]  fetch_pc,
    input  logic                     res_valid,
    input  logic [bp_pkg::xlen-1:0]  res_pc,
    input  logic [bp_pkg::xlen-1:0]  res_target,
    input  logic                     res_taken,
    output logic [index_w-1:0]       fetch_index,
    output logic                     first_slot,
    output logic [bp_pkg::slots-1:0] upd_en,
    output logic [index_w-1:0]       upd_index,
    output logic [bp_pkg::xlen-1:0]  upd_target,
    output logic                     upd_taken
);
    import bp_pkg::*;

    // packet index sits above the 8-byte offset
    assign fetch_index = fetch_pc[index_w+2:3];
    assign first_slot  = fetch_pc[2];  // entry slot within packet

    assign upd_index  = res_pc[index_w+2:3];
    assign upd_target = res_target;
    assign upd_taken  = res_taken;

    // one-hot strobe to the bank owning the resolved slot
    always_comb begin
        upd_en = '0;
        for (int s = 0; s < slots; s++) begin
            upd_en[s] = res_valid && (res_pc[2] == 1'(s));
        end
    end

endmodule

`default_nettype wire

// File: source/bp_bank.sv
// Per-slot prediction bank
`timescale 1ns/1ps
`default_nettype none

module bp_bank #(
    parameter int index_w = 8
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic [index_w-1:0]      fetch_index,
    input  logic                    upd_en,
    input  logic [index_w-1:0]      upd_index,
    input  logic [bp_pkg::xlen-1:0] upd_target,
    input  logic                    upd_taken,
    output logic                    slot_taken,
    output logic [bp_pkg::xlen-1:0] slot_target
);
    import bp_pkg::*;

    localparam int depth = 1 << index_w;

    logic [depth-1:0] valid;
    ctr_t             easy [depth];
    ctr_t             hard [depth];
    logic [1:0]       score;    // >= 2 trusts easy
    ctr_t             pred_ctr;
    ctr_t             easy_old;
    ctr_t             hard_old;
    logic             easy_ok;
    logic             hard_ok;

    // easy counter jumps straight across on a miss
    function automatic ctr_t easy_next(input ctr_t c, input logic t);
        case (c)
            strong_taken: easy_next = t ? strong_taken : weak_not;
            weak_taken:   easy_next = t ? strong_taken : weak_not;
            weak_not:     easy_next = t ? weak_taken : strong_not;
            default:      easy_next = t ? weak_taken : strong_not;
        endcase
    endfunction

    // plain saturating walk strong_taken .. strong_not
    function automatic ctr_t hard_next(input ctr_t c, input logic t);
        case (c)
            strong_taken: hard_next = t ? strong_taken : weak_taken;
            weak_taken:   hard_next = t ? strong_taken : weak_not;
            weak_not:     hard_next = t ? weak_taken : strong_not;
            default:      hard_next = t ? weak_not : strong_not;
        endcase
    endfunction

    bp_target_ram #(
        .index_w(index_w)
    ) bp_target_ram_inst (
        .clk    (clk),
        .rd_addr(fetch_index),
        .rd_data(slot_target),
        .wr_en  (upd_en && upd_taken),
        .wr_addr(upd_index),
        .wr_data(upd_target)
    );

    // prediction side
    assign pred_ctr   = score[1] ? easy[fetch_index] : hard[fetch_index];
    assign slot_taken = valid[fetch_index] && !pred_ctr[0];

    // how each counter did on the resolving branch
    assign easy_old = easy[upd_index];
    assign hard_old = hard[upd_index];
    assign easy_ok  = (!easy_old[0]) == upd_taken;
    assign hard_ok  = (!hard_old[0]) == upd_taken;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= '0;
            score <= 2'd0;
            for (int i = 0; i < depth; i++) begin
                easy[i] <= ctr_reset;
                hard[i] <= ctr_reset;
            end
        end else if (upd_en) begin
            if (valid[upd_index]) begin
                easy[upd_index] <= easy_next(easy_old, upd_taken);
                hard[upd_index] <= hard_next(hard_old, upd_taken);
                if (easy_ok && !hard_ok && score != 2'd3) begin
                    score <= score + 2'd1;
                end else if (hard_ok && !easy_ok && score != 2'd0) begin
                    score <= score - 2'd1;
                end
            end
            if (upd_taken) begin
                valid[upd_index] <= 1'b1;  // target written by the ram
            end
        end
    end

endmodule

`default_nettype wire

// File: source/bp_select.sv
// First-taken slot selector
`timescale 1ns/1ps
`default_nettype none

module bp_select (
    input  logic [bp_pkg::xlen-1:0]                      fetch_pc,
    input  logic                                         first_slot,
    input  logic [bp_pkg::slots-1:0]                     slot_taken,
    input  logic [bp_pkg::slots-1:0][bp_pkg::xlen-1:0]   slot_target,
    output logic                                         pred_taken,
    output logic [bp_pkg::xlen-1:0]                      pred_pc,
    output logic [$clog2(bp_pkg::slots)-1:0]             pred_slot
);
    import bp_pkg::*;

    localparam int pkt_bytes = slots * 4;
    localparam int slot_w    = $clog2(slots);

    logic [xlen-1:0] base;

    assign base = fetch_pc & ~xlen'(pkt_bytes - 1);

    // walk from the top so the lowest counting slot wins
    always_comb begin
        pred_taken = 1'b0;
        pred_pc    = base + xlen'(pkt_bytes);  // fall through
        pred_slot  = '0;
        for (int s = slots - 1; s >= 0; s--) begin
            // slots before the entry point were not fetched
            if (slot_taken[s] && s >= int'(first_slot)) begin
                pred_taken = 1'b1;
                pred_pc    = slot_target[s];
                pred_slot  = slot_w'(s);
            end
        end
    end

endmodule

`default_nettype wire

// File: source/branch_predictor.sv
// Two-slot branch predictor
`timescale 1ns/1ps
`default_nettype none

module branch_predictor #(
    parameter int index_w = 8
) (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic [bp_pkg::xlen-1:0]          fetch_pc,
    input  logic                             res_valid,
    input  logic [bp_pkg::xlen-1:0]          res_pc,
    input  logic [bp_pkg::xlen-1:0]          res_target,
    input  logic                             res_taken,
    output logic                             pred_taken,
    output logic [bp_pkg::xlen-1:0]          pred_pc,
    output logic [$clog2(bp_pkg::slots)-1:0] pred_slot
);
    import bp_pkg::*;

    logic [index_w-1:0]          fetch_index;
    logic                        first_slot;
    logic [slots-1:0]            upd_en;
    logic [index_w-1:0]          upd_index;
    logic [xlen-1:0]             upd_target;
    logic                        upd_taken;
    logic [slots-1:0]            slot_taken;
    logic [slots-1:0][xlen-1:0]  slot_target;

    bp_route #(
        .index_w(index_w)
    ) bp_route_inst (
        .fetch_pc   (fetch_pc),
        .res_valid  (res_valid),
        .res_pc     (res_pc),
        .res_target (res_target),
        .res_taken  (res_taken),
        .fetch_index(fetch_index),
        .first_slot (first_slot),
        .upd_en     (upd_en),
        .upd_index  (upd_index),
        .upd_target (upd_target),
        .upd_taken  (upd_taken)
    );

    // one bank per instruction slot
    for (genvar g = 0; g < slots; g++) begin : g_bank
        bp_bank #(
            .index_w(index_w)
        ) bp_bank_inst (
            .clk        (clk),
            .rstn       (rstn),
            .fetch_index(fetch_index),
            .upd_en     (upd_en[g]),
            .upd_index  (upd_index),
            .upd_target (upd_target),
            .upd_taken  (upd_taken),
            .slot_taken (slot_taken[g]),
            .slot_target(slot_target[g])
        );
    end

    bp_select bp_select_inst (
        .fetch_pc   (fetch_pc),
        .first_slot (first_slot),
        .slot_taken (slot_taken),
        .slot_target(slot_target),
        .pred_taken (pred_taken),
        .pred_pc    (pred_pc),
        .pred_slot  (pred_slot)
    );

endmodule

`default_nettype wire

// File: tb/bp_clock.sv
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module bp_clock #(
    parameter int period_ns    = 100,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1 rstn = 1'b1;  // release just after the edge
    end

endmodule

`default_nettype wire

// File: tb/branch_predictor_tb.sv
// Branch predictor testbench
`timescale 1ns/1ps
`default_nettype none

module branch_predictor_tb;
    import bp_pkg::*;

    localparam int index_w         = 8;
    localparam int depth           = 1 << index_w;
    localparam int period_ns       = 100;
    localparam int watchdog_cycles = 2000;

    logic        clk;
    logic        rstn;
    logic [31:0] fetch_pc;
    logic        res_valid;
    logic [31:0] res_pc;
    logic [31:0] res_target;
    logic        res_taken;
    logic        pred_taken;
    logic [31:0] pred_pc;
    logic [0:0]  pred_slot;

    // reference model state
    logic        valid_m  [slots][depth];
    logic [31:0] target_m [slots][depth];
    ctr_t        easy_m   [slots][depth];
    ctr_t        hard_m   [slots][depth];
    logic [1:0]  score_m  [slots];

    logic [31:0] lfsr = 32'hc75607c9;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          failed_tests = 0;

    bp_clock #(
        .period_ns   (period_ns),
        .reset_cycles(2)
    ) bp_clock_inst (
        .clk (clk),
        .rstn(rstn)
    );

    branch_predictor #(
        .index_w(index_w)
    ) branch_predictor_inst (
        .clk       (clk),
        .rstn      (rstn),
        .fetch_pc  (fetch_pc),
        .res_valid (res_valid),
        .res_pc    (res_pc),
        .res_target(res_target),
        .res_taken (res_taken),
        .pred_taken(pred_taken),
        .pred_pc   (pred_pc),
        .pred_slot (pred_slot)
    );

    // taps x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic says_taken(input ctr_t c);
        return (c == strong_taken) || (c == weak_taken);
    endfunction

    function automatic ctr_t easy_step(input ctr_t c, input logic t);
        if (t) begin
            return says_taken(c) ? strong_taken : weak_taken;
        end
        return says_taken(c) ? weak_not : strong_not;
    endfunction

    // hard counter as a level 0 (strong taken) .. 3 (strong not)
    function automatic ctr_t hard_step(input ctr_t c, input logic t);
        int lvl;
        case (c)
            strong_taken: lvl = 0;
            weak_taken:   lvl = 1;
            weak_not:     lvl = 2;
            default:      lvl = 3;
        endcase
        if (t && lvl > 0) begin
            lvl--;
        end else if (!t && lvl < 3) begin
            lvl++;
        end
        case (lvl)
            0:       return strong_taken;
            1:       return weak_taken;
            2:       return weak_not;
            default: return strong_not;
        endcase
    endfunction

    task automatic reset_model();
        for (int s = 0; s < slots; s++) begin
            score_m[s] = 2'd0;
            for (int i = 0; i < depth; i++) begin
                valid_m[s][i]  = 1'b0;
                target_m[s][i] = 32'h0;
                easy_m[s][i]   = ctr_reset;
                hard_m[s][i]   = ctr_reset;
            end
        end
    endtask

    task automatic apply_update(input logic [31:0] rpc, input logic [31:0] rtgt,
                                input logic rtk);
        int                 b;
        logic [index_w-1:0] i;
        logic               e_ok;
        logic               h_ok;
        b = int'(rpc[2]);
        i = rpc[index_w+2:3];
        if (valid_m[b][i]) begin
            e_ok = says_taken(easy_m[b][i]) == rtk;
            h_ok = says_taken(hard_m[b][i]) == rtk;
            easy_m[b][i] = easy_step(easy_m[b][i], rtk);
            hard_m[b][i] = hard_step(hard_m[b][i], rtk);
            if (e_ok && !h_ok && score_m[b] < 2'd3) begin
                score_m[b] = score_m[b] + 2'd1;
            end else if (h_ok && !e_ok && score_m[b] > 2'd0) begin
                score_m[b] = score_m[b] - 2'd1;
            end
        end
        if (rtk) begin
            target_m[b][i] = rtgt;
            valid_m[b][i]  = 1'b1;
        end
    endtask

    task automatic check_outputs();
        logic [index_w-1:0] idx;
        logic               exp_taken;
        logic [31:0]        exp_pc;
        logic [0:0]         exp_slot;
        logic               hit;
        idx       = fetch_pc[index_w+2:3];
        exp_taken = 1'b0;
        exp_pc    = {fetch_pc[31:3], 3'b000} + 32'd8;  // fall through
        exp_slot  = 1'b0;
        for (int s = 0; s < slots; s++) begin
            hit = valid_m[s][idx] &&
                  says_taken(score_m[s] >= 2'd2 ? easy_m[s][idx] : hard_m[s][idx]);
            if (!exp_taken && hit && s >= int'(fetch_pc[2])) begin
                exp_taken = 1'b1;
                exp_pc    = target_m[s][idx];
                exp_slot  = 1'(s);
            end
        end
        checks++;
        assert (pred_taken === exp_taken) else begin
            $display("mismatch pred_taken: got %h, expected %h", pred_taken, exp_taken);
            errors++;
        end
        assert (pred_pc === exp_pc) else begin
            $display("mismatch pred_pc: got %h, expected %h", pred_pc, exp_pc);
            errors++;
        end
        assert (pred_slot === exp_slot) else begin
            $display("mismatch pred_slot: got %h, expected %h", pred_slot, exp_slot);
            errors++;
        end
    endtask

    // drive 1 ns after the edge and check at the falling edge
    task automatic drive_cycle(input logic [31:0] fpc, input logic rv,
                               input logic [31:0] rpc, input logic [31:0] rtgt,
                               input logic rtk);
        @(posedge clk);
        #1;
        fetch_pc   = fpc;
        res_valid  = rv;
        res_pc     = rpc;
        res_target = rtgt;
        res_taken  = rtk;
        @(negedge clk);
        check_outputs();
        if (rv) begin
            apply_update(rpc, rtgt, rtk);
        end
    endtask

    task automatic fetch_only(input logic [31:0] fpc);
        drive_cycle(fpc, 1'b0, 32'h0, 32'h0, 1'b0);
    endtask

    task automatic resolve(input logic [31:0] fpc, input logic [31:0] rpc,
                           input logic [31:0] rtgt, input logic rtk);
        drive_cycle(fpc, 1'b1, rpc, rtgt, rtk);
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (!rstn && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (!rstn) begin
            $display("reset was not released within 20 cycles");
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int start_errors);
        tests++;
        if (errors == start_errors) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: failed with %0d errors", tests, name,
                     errors - start_errors);
        end
    endtask

    initial begin
        for (int c = 0; c < watchdog_cycles; c++) begin
            #(period_ns);
        end
        $display("timeout after %0d cycles", watchdog_cycles);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        int          start;
        logic [31:0] fpc;
        logic [31:0] rpc;
        logic [31:0] rtgt;
        logic        rv;
        logic        rtk;
        fetch_pc   = 32'h0;
        res_valid  = 1'b0;
        res_pc     = 32'h0;
        res_target = 32'h0;
        res_taken  = 1'b0;
        reset_model();
        wait_reset();

        start = errors;
        for (int n = 0; n < 8; n++) begin
            fetch_only(rand_bits(32) & 32'hffff_fffc);
        end
        finish_test("reset state", start);

        start = errors;
        resolve(32'h0000_1230, 32'h0000_1230, 32'h0000_8000, 1'b1);  // same cycle sees old entry
        fetch_only(32'h0000_1230);
        resolve(32'h0000_2340, 32'h0000_2344, 32'h0000_9004, 1'b1);
        fetch_only(32'h0000_2340);
        fetch_only(32'h0000_2344);
        finish_test("single taken slot", start);

        start = errors;
        resolve(32'h0, 32'h0000_3450, 32'h0000_a000, 1'b1);
        resolve(32'h0, 32'h0000_3454, 32'h0000_b000, 1'b1);
        fetch_only(32'h0000_3450);
        fetch_only(32'h0000_3454);
        finish_test("slot priority", start);

        start = errors;
        resolve(32'h0, 32'h0000_4560, 32'h0000_c000, 1'b1);
        // N N T T walks the chooser toward easy, then a run of not-taken
        for (int i = 0; i < 16; i++) begin
            rtk = (i < 12) && (i % 4 >= 2);
            resolve(32'h0000_4560, 32'h0000_4560, 32'h0000_c000, rtk);
        end
        fetch_only(32'h0000_4560);
        finish_test("counters and chooser", start);

        start = errors;
        for (int n = 0; n < 400; n++) begin
            fpc  = rand_bits(32) & 32'hffff_f81c;  // index 0..3 for heavy aliasing
            rpc  = rand_bits(32) & 32'hffff_f81c;
            rtgt = rand_bits(32) & 32'hffff_fffc;
            rv   = rand_bits(2) != 32'd0;
            rtk  = 1'(rand_bits(1));
            if (rand_bits(2) == 32'd0) begin
                fpc = rpc;
            end
            drive_cycle(fpc, rv, rpc, rtgt, rtk);
        end
        finish_test("random stream", start);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
source/bp_pkg.sv
source/bp_target_ram.sv
source/bp_route.sv
source/bp_bank.sv
source/bp_select.sv
source/branch_predictor.sv
tb/bp_clock.sv
tb/branch_predictor_tb.sv

// File: run.sh
#!/bin/sh
# build and run the branch predictor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f files.f --top-module branch_predictor_tb -o sim_bp

./obj_dir/sim_bp > sim.log 2>&1
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
exit 0
